// File: drac_mem.f
+incdir+include
verilog/drac_mem_pkg.sv
verilog/mem_cfg_regs.sv
verilog/mem_unit.sv
verilog/dcache_lite.sv
verilog/mem_subsys_top.sv
dv/tb_clk_gen.sv
dv/mem_unit_checker.sv
dv/tb_mem_subsys.sv

// File: dv/mem_unit_checker.sv
// ----------------------------------------
// lock and request protocol assertions for mem_unit
// ----------------------------------------
`default_nettype none

`include "drac_mem_settings.svh"

module mem_unit_checker (
    input logic                        clk_i,
    input logic                        rstn_i,
    input drac_mem_pkg::mem_state_t    state_i,
    input logic                        lock_i,
    input logic                        req_valid_i,
    input logic                        req_ready_i,
    input drac_mem_pkg::dcache_req_t   req_i,
    input drac_mem_pkg::dcache_resp_t  resp_i,
    input logic                        ready_i,
    input logic                        xcpt_i
);

    import drac_mem_pkg::*;

    localparam int LAT = `DRAC_DCACHE_LAT;

    logic io_store;

    assign io_store = req_i.io && (req_i.cmd == CMD_ST);   // posted, never answered

    // ----------------------------------------
    // protocol properties
    // ----------------------------------------
    // lock only drops in the cycle that closes the operation
    a_lock_pending: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_i != ST_IDLE && !lock_i) |=> (state_i == ST_IDLE))
        else $error("lock_o low while an operation is still pending");

    a_req_ready: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(req_valid_i && !req_ready_i))
        else $error("request strobe while the cache is not ready");

    a_resp_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (req_valid_i && !io_store) |-> ##LAT resp_i.valid)
        else $error("cache response missing after the fixed latency");

    a_reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |-> !(lock_i || req_valid_i || ready_i || xcpt_i))
        else $error("memory stage outputs active during reset");

endmodule

bind mem_unit mem_unit_checker i_mem_unit_checker (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .state_i     (state_q),
    .lock_i      (lock_o),
    .req_valid_i (req_valid_o),
    .req_ready_i (req_ready_i),
    .req_i       (req_o),
    .resp_i      (resp_i),
    .ready_i     (ready_o),
    .xcpt_i      (xcpt_o)
);

`default_nettype wire

// File: dv/tb_clk_gen.sv
// ----------------------------------------
// testbench clock and reset
// ----------------------------------------
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;   // period 100
    end

    initial begin
        rstn_o <= 1'b0;
        repeat (8) @(posedge clk_o);
        rstn_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_mem_subsys.sv
// ----------------------------------------
// memory subsystem testbench with mirror memory,
// reference functions and compare process
// ----------------------------------------
`default_nettype none

`include "drac_mem_settings.svh"

module tb_mem_subsys;

    import drac_mem_pkg::*;

    localparam int LAT            = `DRAC_DCACHE_LAT;
    localparam int TIMEOUT_CYCLES = 4000;   // ~160 ops of ~7 cycles, plus margin

    logic       clk_i, rstn_i;
    logic       cfg_we_i, cfg_sel_i, valid_i, kill_i;
    addr_t      cfg_wdata_i;
    mem_instr_t instr_i;
    logic       ready_o, lock_o, xcpt_o;
    bus64_t     data_o;

    bus64_t mirror [`DRAC_MEM_WORDS];
    integer seed = 39330;
    int     errors = 0, errors_at_start = 0, checks = 0, tests = 0, cycles = 0;
    string  cur_name = "reset";
    logic   exp_ready = 1'b0;
    bus64_t exp_data = '0;
    int     ready_seen = 0, xcpt_seen = 0;

    tb_clk_gen i_tb_clk_gen (.clk_o(clk_i), .rstn_o(rstn_i));

    mem_subsys_top i_mem_subsys_top (
        .clk_i (clk_i), .rstn_i (rstn_i),
        .cfg_we_i (cfg_we_i), .cfg_sel_i (cfg_sel_i), .cfg_wdata_i (cfg_wdata_i),
        .valid_i (valid_i), .kill_i (kill_i), .instr_i (instr_i),
        .ready_o (ready_o), .data_o (data_o), .lock_o (lock_o), .xcpt_o (xcpt_o)
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic int word_index(input addr_t a);
        return (a >> 3) % `DRAC_MEM_WORDS;
    endfunction

    // lane picked by the low address bits, then sign or zero extended
    function automatic bus64_t load_value(input bus64_t word, input addr_t a, input mem_fmt_t f);
        int     nbits;
        bus64_t lane, mask;
        nbits = 8 << f[1:0];
        lane  = word >> (8 * a[2:0]);
        if (nbits < 64) begin
            mask = (64'd1 << nbits) - 1;
            lane = lane & mask;
            if (!f[2] && lane[nbits-1])
                lane = lane | ~mask;
        end
        return lane;
    endfunction

    function automatic bus64_t merge_store(input bus64_t word, input addr_t a,
                                           input mem_fmt_t f, input bus64_t d);
        int     nbits;
        bus64_t mask;
        nbits = 8 << f[1:0];
        mask  = (nbits == 64) ? {64{1'b1}} : ((64'd1 << nbits) - 1);
        mask  = mask << (8 * a[2:0]);
        return (word & ~mask) | ((d << (8 * a[2:0])) & mask);
    endfunction

    // word AMOs compare only the low 32 bits
    function automatic bus64_t amo_result(input amo_op_t op, input bus64_t a,
                                          input bus64_t b, input logic word);
        logic lt_s, lt_u;
        if (word) begin
            lt_s = $signed(a[31:0]) < $signed(b[31:0]);
            lt_u = a[31:0] < b[31:0];
        end else begin
            lt_s = $signed(a) < $signed(b);
            lt_u = a < b;
        end
        case (op)
            AMO_SWAP: return b;
            AMO_ADD:  return a + b;
            AMO_XOR:  return a ^ b;
            AMO_AND:  return a & b;
            AMO_OR:   return a | b;
            AMO_MIN:  return lt_s ? a : b;
            AMO_MAX:  return lt_s ? b : a;
            AMO_MINU: return lt_u ? a : b;
            AMO_MAXU: return lt_u ? b : a;
            default:  return a;
        endcase
    endfunction

    function automatic bus64_t random_offset();
        return bus64_t'($random(seed) & 32'hFF);
    endfunction

    function automatic mem_instr_t make_instr(input mem_op_t op, input amo_op_t amo,
                                              input mem_fmt_t fmt, input addr_t addr,
                                              input bus64_t data, input bus64_t off);
        mem_instr_t ins;
        ins     = '0;
        ins.op  = op;
        ins.amo = amo;
        ins.fmt = fmt;
        ins.rd  = 5'd10;
        ins.rs2 = data;
        ins.imm = off;   // ignored by AMOs
        ins.rs1 = (op == MEM_AMO) ? {32'b0, addr} : {32'b0, addr} - off;
        return ins;
    endfunction

    // ----------------------------------------
    // compare process and timeout
    // ----------------------------------------
    always @(negedge clk_i) begin
        if (rstn_i && ready_o) begin
            ready_seen++;
            if (!exp_ready) begin
                $display("test %s: ready_o raised where no result was expected", cur_name);
                errors++;
            end else if (data_o !== exp_data) begin
                $display("FAILED %s expected %h actual %h", cur_name, exp_data, data_o);
                errors++;
            end
        end
        if (rstn_i && xcpt_o)
            xcpt_seen++;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus tasks
    // ----------------------------------------
    task automatic run_op(input mem_instr_t ins, input logic want_ready,
                          input bus64_t want_data, input logic want_xcpt);
        exp_ready  = want_ready;
        exp_data   = want_data;
        ready_seen = 0;
        xcpt_seen  = 0;
        @(posedge clk_i);
        valid_i <= 1'b1;
        instr_i <= ins;
        do @(posedge clk_i); while (lock_o);
        valid_i <= 1'b0;
        repeat (LAT + 1) @(posedge clk_i);   // catch late pulses
        checks++;
        if (ready_seen != (want_ready ? 1 : 0)) begin
            $display("test %s: %0d ready_o pulses seen, %0d expected", cur_name,
                     ready_seen, want_ready ? 1 : 0);
            errors++;
        end
        if (xcpt_seen != (want_xcpt ? 1 : 0)) begin
            $display("test %s: %0d xcpt_o pulses seen, %0d expected", cur_name,
                     xcpt_seen, want_xcpt ? 1 : 0);
            errors++;
        end
    endtask

    // kill either with the first valid cycle or one cycle after the strobe
    task automatic run_kill(input mem_instr_t ins, input int delay);
        exp_ready  = 1'b0;
        ready_seen = 0;
        xcpt_seen  = 0;
        @(posedge clk_i);
        valid_i <= 1'b1;
        instr_i <= ins;
        kill_i  <= (delay == 0);
        if (delay > 0) begin
            @(posedge clk_i);
            kill_i <= 1'b1;
        end
        @(posedge clk_i);
        kill_i  <= 1'b0;
        valid_i <= 1'b0;
        checks++;
        if (lock_o) begin
            $display("test %s: lock_o still high in the kill cycle", cur_name);
            errors++;
        end
        repeat (LAT + 1) @(posedge clk_i);
        if (ready_seen != 0 || xcpt_seen != 0) begin
            $display("test %s: killed operation still returned a result", cur_name);
            errors++;
        end
    endtask

    task automatic store_mirrored(input addr_t addr, input mem_fmt_t fmt, input bus64_t data);
        run_op(make_instr(MEM_STORE, AMO_SWAP, fmt, addr, data, random_offset()), 1'b0, '0, 1'b0);
        mirror[word_index(addr)] = merge_store(mirror[word_index(addr)], addr, fmt, data);
    endtask

    task automatic load_check(input addr_t addr, input mem_fmt_t fmt);
        run_op(make_instr(MEM_LOAD, AMO_SWAP, fmt, addr, '0, random_offset()), 1'b1,
               load_value(mirror[word_index(addr)], addr, fmt), 1'b0);
    endtask

    task automatic write_cfg(input logic sel, input addr_t value);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_sel_i   <= sel;
        cfg_wdata_i <= value;
        @(posedge clk_i);
        cfg_we_i    <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_name        = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests++;
        if (errors == errors_at_start)
            $display("test %-12s ok", cur_name);
        else
            $display("test %-12s %0d error(s)", cur_name, errors - errors_at_start);
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        addr_t    addr;
        mem_fmt_t fmt;
        bus64_t   data, old;
        cfg_we_i    = 1'b0;
        cfg_sel_i   = 1'b0;
        cfg_wdata_i = '0;
        valid_i     = 1'b0;
        kill_i      = 1'b0;
        instr_i     = '0;
        wait (rstn_i);
        repeat (2) @(posedge clk_i);

        begin_test("store_load");
        for (int i = 0; i < 40; i++) begin
            fmt  = mem_fmt_t'(i % 7);   // every size and sign
            addr = addr_t'($random(seed)) & 32'h0000_07FF;
            addr = addr & ~addr_t'((1 << fmt[1:0]) - 1);
            store_mirrored(addr, {1'b0, fmt[1:0]}, {$random(seed), $random(seed)});
            load_check(addr, fmt);
        end
        finish_test();

        begin_test("amo");
        for (int k = 0; k < 9; k++) begin
            for (int w = 0; w < 2; w++) begin
                fmt  = (w == 1) ? 3'b010 : 3'b011;
                addr = 32'h0000_0200 + 16 * k + 8 * w + 4 * w * (k % 2);
                store_mirrored(addr & ~32'h7, 3'b011, {$random(seed), $random(seed)});
                data = {$random(seed), $random(seed)};
                old  = load_value(mirror[word_index(addr)], addr, fmt);
                run_op(make_instr(MEM_AMO, amo_op_t'(k), fmt, addr, data, random_offset()),
                       1'b1, old, 1'b0);
                mirror[word_index(addr)] = merge_store(mirror[word_index(addr)], addr, fmt,
                                                       amo_result(amo_op_t'(k), old, data, w == 1));
                load_check(addr, fmt);
            end
        end
        finish_test();

        begin_test("misaligned");
        for (int j = 1; j < 4; j++) begin
            fmt  = mem_fmt_t'(j);
            addr = 32'h0000_0300 + 8 * j;
            store_mirrored(addr, 3'b011, {$random(seed), $random(seed)});
            run_op(make_instr(MEM_STORE, AMO_SWAP, fmt, addr + 1, {$random(seed), $random(seed)},
                              random_offset()), 1'b0, '0, 1'b1);
            run_op(make_instr(MEM_LOAD, AMO_SWAP, fmt, addr + 3, '0, random_offset()),
                   1'b0, '0, 1'b1);
            load_check(addr, 3'b011);   // memory untouched
        end
        finish_test();

        begin_test("kill");
        addr = 32'h0000_0380;
        store_mirrored(addr, 3'b011, {$random(seed), $random(seed)});
        run_kill(make_instr(MEM_STORE, AMO_SWAP, 3'b011, addr, ~mirror[word_index(addr)],
                            random_offset()), 0);
        run_kill(make_instr(MEM_LOAD, AMO_SWAP, 3'b011, addr, '0, random_offset()), 1);
        load_check(addr, 3'b011);
        finish_test();

        begin_test("io_window");
        store_mirrored(32'h0000_0400, 3'b011, {$random(seed), $random(seed)});
        store_mirrored(32'h0000_0500, 3'b011, {$random(seed), $random(seed)});
        write_cfg(1'b0, 32'h0000_0400);
        write_cfg(1'b1, 32'h0000_04FF);
        // posted store on the base bound, memory keeps its old word
        run_op(make_instr(MEM_STORE, AMO_SWAP, 3'b011, 32'h0000_0400,
                          ~mirror[word_index(32'h0000_0400)], random_offset()), 1'b0, '0, 1'b0);
        load_check(32'h0000_0400, 3'b011);
        store_mirrored(32'h0000_0500, 3'b011, {$random(seed), $random(seed)});   // limit + 1
        load_check(32'h0000_0500, 3'b011);
        finish_test();

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: include/drac_mem_settings.svh
// ----------------------------------------
// widths, memory depth, cache latency and
// IO window reset bounds for the memory subsystem
// ----------------------------------------
`ifndef DRAC_MEM_SETTINGS_SVH
`define DRAC_MEM_SETTINGS_SVH

// datapath
`define DRAC_XLEN 64
`define DRAC_AW 32

// data cache geometry and timing
`define DRAC_MEM_WORDS 256
`define DRAC_DCACHE_LAT 2   // accept to response, in cycles

// io window, both bounds inclusive
`define DRAC_IO_BASE_RST 32'h0000_8000
`define DRAC_IO_LIMIT_RST 32'h0000_80FF

`endif

// File: verilog/dcache_lite.sv
// ----------------------------------------
// fixed latency data memory with loads, stores,
// AMO read-modify-write and misalign check
// ----------------------------------------
`default_nettype none

`include "drac_mem_settings.svh"

module dcache_lite (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        req_valid_i,
    input  drac_mem_pkg::dcache_req_t   req_i,
    output logic                        req_ready_o,
    output drac_mem_pkg::dcache_resp_t  resp_o
);

    import drac_mem_pkg::*;

    localparam int IDX_W = $clog2(`DRAC_MEM_WORDS);
    localparam int LAT   = `DRAC_DCACHE_LAT;
    localparam int CNT_W = $clog2(LAT + 1);

    bus64_t           mem_q [`DRAC_MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [5:0]       shamt;
    bus64_t           old_word, lane, ld_val;
    bus64_t           amo_b, amo_res, wr_data, size_mask, wr_mask;
    logic             is_store, is_amo, ma, accept, wr_en, resp_en;
    logic [CNT_W-1:0] busy_q;
    logic [LAT-1:0]   vld_q;
    logic [LAT-1:0]   ma_q;
    bus64_t           data_q [LAT];

    assign idx      = req_i.addr[IDX_W+2:3];
    assign shamt    = {req_i.addr[2:0], 3'b000};
    assign old_word = mem_q[idx];
    assign lane     = old_word >> shamt;
    assign is_store = (req_i.cmd == CMD_ST);
    assign is_amo   = (req_i.cmd != CMD_ST) && (req_i.cmd != CMD_LD);

    // ----------------------------------------
    // read side
    // ----------------------------------------
    always_comb begin
        case (req_i.fmt)
            3'b000:  ld_val = {{56{lane[7]}}, lane[7:0]};
            3'b001:  ld_val = {{48{lane[15]}}, lane[15:0]};
            3'b010:  ld_val = {{32{lane[31]}}, lane[31:0]};   // word AMO old value too
            3'b100:  ld_val = {56'b0, lane[7:0]};
            3'b101:  ld_val = {48'b0, lane[15:0]};
            3'b110:  ld_val = {32'b0, lane[31:0]};
            default: ld_val = lane;
        endcase
    end

    always_comb begin
        case (req_i.fmt[1:0])
            2'b01:   ma = req_i.addr[0];
            2'b10:   ma = |req_i.addr[1:0];
            2'b11:   ma = |req_i.addr[2:0];
            default: ma = 1'b0;
        endcase
    end

    // ----------------------------------------
    // AMO arithmetic and write merge
    // ----------------------------------------
    // sign-extended word operands keep unsigned order intact
    assign amo_b = (req_i.fmt[1:0] == 2'b10) ? {{32{req_i.data[31]}}, req_i.data[31:0]}
                                             : req_i.data;

    always_comb begin
        case (req_i.cmd)
            CMD_SWAP: amo_res = amo_b;
            CMD_ADD:  amo_res = ld_val + amo_b;
            CMD_XOR:  amo_res = ld_val ^ amo_b;
            CMD_AND:  amo_res = ld_val & amo_b;
            CMD_OR:   amo_res = ld_val | amo_b;
            CMD_MIN:  amo_res = ($signed(ld_val) < $signed(amo_b)) ? ld_val : amo_b;
            CMD_MAX:  amo_res = ($signed(ld_val) > $signed(amo_b)) ? ld_val : amo_b;
            CMD_MINU: amo_res = (ld_val < amo_b) ? ld_val : amo_b;
            CMD_MAXU: amo_res = (ld_val > amo_b) ? ld_val : amo_b;
            default:  amo_res = ld_val;
        endcase
    end

    always_comb begin
        case (req_i.fmt[1:0])
            2'b00:   size_mask = 64'h0000_0000_0000_00ff;
            2'b01:   size_mask = 64'h0000_0000_0000_ffff;
            2'b10:   size_mask = 64'h0000_0000_ffff_ffff;
            default: size_mask = '1;
        endcase
    end

    assign wr_data = (is_amo ? amo_res : req_i.data) << shamt;
    assign wr_mask = size_mask << shamt;

    assign accept  = req_valid_i && req_ready_o;
    assign wr_en   = accept && !ma && (is_amo || (is_store && !req_i.io));
    assign resp_en = accept && !(is_store && req_i.io);   // io stores are posted

    always_ff @(posedge clk_i) begin
        if (wr_en) mem_q[idx] <= (old_word & ~wr_mask) | (wr_data & wr_mask);
    end

    // ----------------------------------------
    // busy counter and latency pipeline
    // ----------------------------------------
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i)              busy_q <= '0;
        else if (accept)          busy_q <= CNT_W'(LAT - 1);
        else if (busy_q != '0)    busy_q <= busy_q - 1'b1;
    end

    assign req_ready_o = (busy_q == '0);

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= resp_en;
            for (int i = 1; i < LAT; i++) vld_q[i] <= vld_q[i-1];
        end
    end

    always_ff @(posedge clk_i) begin
        data_q[0] <= ld_val;
        ma_q[0]   <= ma;
        for (int i = 1; i < LAT; i++) begin
            data_q[i] <= data_q[i-1];
            ma_q[i]   <= ma_q[i-1];
        end
    end

    always_comb begin
        resp_o.valid   = vld_q[LAT-1];
        resp_o.data    = data_q[LAT-1];
        resp_o.xcpt_ma = ma_q[LAT-1];
    end

endmodule

`default_nettype wire

// File: verilog/drac_mem_pkg.sv
// ----------------------------------------
// bus, operation and command types for the memory stage
// ----------------------------------------
`default_nettype none

`include "drac_mem_settings.svh"

package drac_mem_pkg;

    typedef logic [`DRAC_XLEN-1:0] bus64_t;
    typedef logic [`DRAC_AW-1:0]   addr_t;
    typedef logic [4:0]            reg_t;
    typedef logic [2:0]            mem_fmt_t;   // funct3, bit 2 set means unsigned

    typedef enum logic [1:0] {MEM_LOAD, MEM_STORE, MEM_AMO} mem_op_t;

    typedef enum logic [3:0] {
        AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR,
        AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU
    } amo_op_t;

    // cache command codes
    typedef enum logic [4:0] {
        CMD_LD   = 5'b00000,
        CMD_ST   = 5'b00001,
        CMD_SWAP = 5'b00100,
        CMD_ADD  = 5'b01000,
        CMD_XOR  = 5'b01001,
        CMD_OR   = 5'b01010,
        CMD_AND  = 5'b01011,
        CMD_MIN  = 5'b01100,
        CMD_MAX  = 5'b01101,
        CMD_MINU = 5'b01110,
        CMD_MAXU = 5'b01111
    } dcache_cmd_t;

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} mem_state_t;

    typedef struct packed {
        mem_op_t  op;
        amo_op_t  amo;
        mem_fmt_t fmt;
        reg_t     rd;
        bus64_t   rs1;
        bus64_t   rs2;
        bus64_t   imm;
    } mem_instr_t;

    typedef struct packed {
        dcache_cmd_t cmd;
        addr_t       addr;
        mem_fmt_t    fmt;
        bus64_t      data;
        logic        io;   // address falls in the io window
    } dcache_req_t;

    typedef struct packed {
        logic   valid;
        bus64_t data;
        logic   xcpt_ma;
    } dcache_resp_t;

endpackage

`default_nettype wire

// File: verilog/mem_cfg_regs.sv
// ----------------------------------------
// io window base and limit registers, io address decode
// ----------------------------------------
`default_nettype none

`include "drac_mem_settings.svh"

module mem_cfg_regs (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  cfg_we_i,
    input  logic                  cfg_sel_i,   // 0 base, 1 limit
    input  drac_mem_pkg::addr_t   cfg_wdata_i,
    input  drac_mem_pkg::addr_t   addr_i,
    output logic                  io_hit_o
);

    import drac_mem_pkg::*;

    addr_t io_base_q;
    addr_t io_limit_q;

    // ----------------------------------------
    // window registers
    // ----------------------------------------
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            io_base_q  <= `DRAC_IO_BASE_RST;
            io_limit_q <= `DRAC_IO_LIMIT_RST;
        end else if (cfg_we_i) begin
            if (cfg_sel_i) io_limit_q <= cfg_wdata_i;
            else           io_base_q  <= cfg_wdata_i;
        end
    end

    // inclusive on both ends
    assign io_hit_o = (addr_i >= io_base_q) && (addr_i <= io_limit_q);

endmodule

`default_nettype wire

// File: verilog/mem_subsys_top.sv
// ----------------------------------------
// memory subsystem top with config regs,
// memory stage and data cache
// ----------------------------------------
`default_nettype none

module mem_subsys_top (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      cfg_we_i,
    input  logic                      cfg_sel_i,
    input  drac_mem_pkg::addr_t       cfg_wdata_i,
    input  logic                      valid_i,
    input  logic                      kill_i,
    input  drac_mem_pkg::mem_instr_t  instr_i,
    output logic                      ready_o,
    output drac_mem_pkg::bus64_t      data_o,
    output logic                      lock_o,
    output logic                      xcpt_o
);

    import drac_mem_pkg::*;

    addr_t        mem_addr;
    logic         io_hit;
    logic         dc_req_valid;
    logic         dc_req_ready;
    dcache_req_t  dc_req;
    dcache_resp_t dc_resp;

    mem_cfg_regs i_mem_cfg_regs (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_sel_i   (cfg_sel_i),
        .cfg_wdata_i (cfg_wdata_i),
        .addr_i      (mem_addr),
        .io_hit_o    (io_hit)
    );

    mem_unit i_mem_unit (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .valid_i     (valid_i),
        .kill_i      (kill_i),
        .instr_i     (instr_i),
        .io_hit_i    (io_hit),
        .addr_o      (mem_addr),
        .req_valid_o (dc_req_valid),
        .req_o       (dc_req),
        .req_ready_i (dc_req_ready),
        .resp_i      (dc_resp),
        .ready_o     (ready_o),
        .data_o      (data_o),
        .lock_o      (lock_o),
        .xcpt_o      (xcpt_o)
    );

    dcache_lite i_dcache_lite (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_valid_i (dc_req_valid),
        .req_i       (dc_req),
        .req_ready_o (dc_req_ready),
        .resp_o      (dc_resp)
    );

endmodule

`default_nettype wire

// File: verilog/mem_unit.sv
// ----------------------------------------
// memory stage controller with address generation,
// cache command encoding, request FSM and lock
// ----------------------------------------
`default_nettype none

`include "drac_mem_settings.svh"

module mem_unit (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  logic                        valid_i,
    input  logic                        kill_i,
    input  drac_mem_pkg::mem_instr_t    instr_i,
    input  logic                        io_hit_i,
    output drac_mem_pkg::addr_t         addr_o,
    output logic                        req_valid_o,
    output drac_mem_pkg::dcache_req_t   req_o,
    input  logic                        req_ready_i,
    input  drac_mem_pkg::dcache_resp_t  resp_i,
    output logic                        ready_o,
    output drac_mem_pkg::bus64_t        data_o,
    output logic                        lock_o,
    output logic                        xcpt_o
);

    import drac_mem_pkg::*;

    mem_state_t  state_q, state_d;
    bus64_t      eff_addr;
    dcache_cmd_t cmd;
    logic        io_store;    // posted, no response comes back
    logic        resp_take;

    // ----------------------------------------
    // address and command
    // ----------------------------------------
    assign eff_addr = (instr_i.op == MEM_AMO) ? instr_i.rs1 : instr_i.rs1 + instr_i.imm;
    assign addr_o   = eff_addr[`DRAC_AW-1:0];
    assign io_store = (instr_i.op == MEM_STORE) && io_hit_i;

    always_comb begin
        case (instr_i.op)
            MEM_STORE: cmd = CMD_ST;
            MEM_AMO: begin
                case (instr_i.amo)
                    AMO_SWAP: cmd = CMD_SWAP;
                    AMO_ADD:  cmd = CMD_ADD;
                    AMO_XOR:  cmd = CMD_XOR;
                    AMO_AND:  cmd = CMD_AND;
                    AMO_OR:   cmd = CMD_OR;
                    AMO_MIN:  cmd = CMD_MIN;
                    AMO_MAX:  cmd = CMD_MAX;
                    AMO_MINU: cmd = CMD_MINU;
                    AMO_MAXU: cmd = CMD_MAXU;
                    default:  cmd = CMD_LD;
                endcase
            end
            default:   cmd = CMD_LD;
        endcase
    end

    always_comb begin
        req_o      = '0;
        req_o.cmd  = cmd;
        req_o.addr = addr_o;
        req_o.fmt  = instr_i.fmt;
        req_o.data = instr_i.rs2;
        req_o.io   = io_hit_i;
    end

    // ----------------------------------------
    // request FSM and lock
    // ----------------------------------------
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) state_q <= ST_IDLE;
        else         state_q <= state_d;
    end

    always_comb begin
        state_d     = state_q;
        req_valid_o = 1'b0;
        lock_o      = 1'b0;
        case (state_q)
            ST_IDLE: begin
                req_valid_o = valid_i && !kill_i && req_ready_i;
                lock_o      = valid_i && !kill_i;   // also covers back-pressure
                if (req_valid_o) state_d = ST_REQ;
            end
            ST_REQ: begin
                // io store ends here, short latency may answer here too
                if (kill_i || io_store || resp_i.valid) begin
                    state_d = ST_IDLE;
                end else begin
                    lock_o  = 1'b1;
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (kill_i || resp_i.valid) state_d = ST_IDLE;
                else                        lock_o  = 1'b1;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // a response is only taken while an operation is pending,
    // so answers to killed requests land in idle and are dropped
    assign resp_take = resp_i.valid && (state_q != ST_IDLE) && !kill_i;

    assign ready_o = resp_take && !resp_i.xcpt_ma && (instr_i.op != MEM_STORE);
    assign xcpt_o  = resp_take && resp_i.xcpt_ma;
    assign data_o  = resp_i.data;

endmodule

`default_nettype wire
